// File: design/memc_types_pkg.sv
`default_nettype none

package memc_types_pkg;

  localparam int MAX_ADDR_WIDTH = 12;  // widest address any request can carry

  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } memc_op_e;

  // host request, addr is cut down to the BRAM depth in the controller
  typedef struct packed {
    logic                      valid;
    memc_op_e                  op;
    logic [MAX_ADDR_WIDTH-1:0] addr;
    logic [7:0]                wdata;
  } memc_req_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] rdata;
  } memc_rsp_t;

  typedef enum logic [1:0] {
    reg_ctrl      = 2'd0,
    reg_status    = 2'd1,
    reg_fail_addr = 2'd2
  } cfg_addr_e;

  typedef struct packed {
    logic       valid;
    logic       write;  // 0 = read
    cfg_addr_e  addr;
    logic [7:0] wdata;
  } cfg_req_t;

endpackage

`default_nettype wire

// File: design/memc_bist_pkg.sv
`default_nettype none

package memc_bist_pkg;

  typedef enum logic [3:0] {
    st_reset,
    st_bist,
    st_test_wr1,
    st_test_rd1,
    st_test_dec1,
    st_test_wr2,
    st_test_rd2,
    st_test_dec2,
    st_error,
    st_idle,
    st_access,
    st_read_wait
  } memc_state_e;

  localparam logic [7:0] WR_PATT_1 = 8'h55;
  localparam logic [7:0] WR_PATT_2 = 8'hAA;  // left in memory after a clean run

  typedef struct packed {
    logic                                     done;
    logic                                     fail;
    logic                                     busy;
    logic [memc_types_pkg::MAX_ADDR_WIDTH-1:0] fail_addr;
  } bist_status_t;

endpackage

`default_nettype wire

// File: design/memc_req_queue.sv
`timescale 1ns/1ps
`default_nettype none

module memc_req_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                      memc_clk,
  input  logic                      memc_reset,
  input  memc_types_pkg::memc_req_t req,
  input  logic                      pop,
  output memc_types_pkg::memc_req_t head,
  output logic                      credit_return
);

  import memc_types_pkg::*;

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  memc_req_t        slots [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push = req.valid;

  always_comb begin
    head       = slots[rd_ptr];
    head.valid = (count != '0);
  end

  always_ff @(posedge memc_clk) begin
    if (push) slots[wr_ptr] <= req;
  end

  always_ff @(posedge memc_clk) begin
    if (!memc_reset) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      credit_return <= pop;  // one credit back per entry taken
      if (push) wr_ptr <= ptr_inc(wr_ptr);
      if (pop) rd_ptr <= ptr_inc(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // host must never send without a credit
  a_no_overflow: assert property (@(posedge memc_clk) disable iff (!memc_reset)
    push |-> count != CNT_W'(QUEUE_DEPTH));

  a_no_underflow: assert property (@(posedge memc_clk) disable iff (!memc_reset)
    pop |-> count != '0);

endmodule

`default_nettype wire

// File: design/memc_bram.sv
`timescale 1ns/1ps
`default_nettype none

module memc_bram #(
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_WIDTH = 6
) (
  input  logic                  memc_clk,
  input  logic                  en,
  input  logic                  we,
  input  logic [ADDR_WIDTH-1:0] addr,
  input  logic [DATA_WIDTH-1:0] wdata,
  output logic [DATA_WIDTH-1:0] rdata
);

  logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

  // single port, write has priority over read on the same edge
  always_ff @(posedge memc_clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end else begin
        rdata <= mem[addr];  // valid the cycle after en
      end
    end
  end

endmodule

`default_nettype wire

// File: design/memc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module memc_ctrl #(
  parameter int ADDR_WIDTH = 6
) (
  input  logic                        memc_clk,
  input  logic                        memc_reset,
  input  memc_types_pkg::memc_req_t   head,
  output logic                        pop,
  output memc_types_pkg::memc_rsp_t   rsp,
  output logic                        bram_en,
  output logic                        bram_we,
  output logic [ADDR_WIDTH-1:0]       bram_addr,
  output logic [7:0]                  bram_wdata,
  input  logic [7:0]                  bram_rdata,
  input  logic                        bist_start,
  output memc_bist_pkg::bist_status_t status
);

  import memc_types_pkg::*;
  import memc_bist_pkg::*;

  memc_state_e         state;
  memc_state_e         state_next;
  logic [ADDR_WIDTH:0] bist_addr;  // top bit set once the last word passed
  logic                rerun;
  logic                rsp_valid;
  logic [7:0]          rsp_rdata;

  assign rerun = (state == st_idle) && bist_start;
  assign pop   = (state == st_idle) && head.valid && !bist_start;
  assign rsp   = '{valid: rsp_valid, rdata: rsp_rdata};

  always_comb begin
    state_next = state;
    case (state)
      st_reset:     state_next = st_bist;
      st_bist:      state_next = bist_addr[ADDR_WIDTH] ? st_idle : st_test_wr1;
      st_test_wr1:  state_next = st_test_rd1;
      st_test_rd1:  state_next = st_test_dec1;
      st_test_dec1: state_next = (bram_rdata == WR_PATT_1) ? st_test_wr2 : st_error;
      st_test_wr2:  state_next = st_test_rd2;
      st_test_rd2:  state_next = st_test_dec2;
      st_test_dec2: state_next = (bram_rdata == WR_PATT_2) ? st_bist : st_error;
      st_error:     state_next = st_error;  // stuck until reset
      st_idle: begin
        if (bist_start) begin
          state_next = st_bist;
        end else if (head.valid) begin
          state_next = st_access;
        end
      end
      st_access:    state_next = bram_we ? st_idle : st_read_wait;
      st_read_wait: state_next = st_idle;
      default:      state_next = st_reset;
    endcase
  end

  // BRAM strobes are set up for the state being entered
  always_ff @(posedge memc_clk) begin
    if (!memc_reset) begin
      state            <= st_reset;
      bist_addr        <= '0;
      bram_en          <= 1'b0;
      bram_we          <= 1'b0;
      rsp_valid        <= 1'b0;
      status.done      <= 1'b0;
      status.fail      <= 1'b0;
      status.busy      <= 1'b1;
      status.fail_addr <= '0;
    end else begin
      state     <= state_next;
      rsp_valid <= (state == st_read_wait);
      bram_en   <= state_next inside {st_test_wr1, st_test_rd1, st_test_wr2,
                                      st_test_rd2, st_access};
      bram_we   <= (state_next inside {st_test_wr1, st_test_wr2}) ||
                   (state_next == st_access && head.op == op_write);

      if (rerun) begin
        bist_addr   <= '0;
        status.done <= 1'b0;
        status.busy <= 1'b1;
      end else if (state == st_test_dec2 && state_next == st_bist) begin
        bist_addr <= bist_addr + 1'b1;
      end

      if (state == st_bist && bist_addr[ADDR_WIDTH]) begin
        status.done <= 1'b1;
        status.busy <= 1'b0;
      end

      if (state != st_error && state_next == st_error) begin
        status.fail      <= 1'b1;
        status.fail_addr <= MAX_ADDR_WIDTH'(bist_addr[ADDR_WIDTH-1:0]);
      end
    end
  end

  always_ff @(posedge memc_clk) begin
    case (state_next)
      st_test_wr1: begin
        bram_addr  <= bist_addr[ADDR_WIDTH-1:0];
        bram_wdata <= WR_PATT_1;
      end
      st_test_wr2: bram_wdata <= WR_PATT_2;  // same address as wr1
      st_access: begin
        bram_addr  <= head.addr[ADDR_WIDTH-1:0];  // drop unused upper bits
        bram_wdata <= head.wdata;
      end
      default: begin
      end
    endcase
    if (state == st_read_wait) rsp_rdata <= bram_rdata;
  end

  // host pops only once the test is over, BRAM driven on the next cycle
  a_pop_idle: assert property (@(posedge memc_clk) disable iff (!memc_reset)
    pop |-> !status.busy ##1 (state == st_access && bram_en));

  // once the test is over, only host accesses may write
  a_we_access: assert property (@(posedge memc_clk) disable iff (!memc_reset)
    $rose(bram_we) && !status.busy |-> state == st_access);

endmodule

`default_nettype wire

// File: design/memc_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module memc_cfg_regs #(
  parameter int ADDR_WIDTH = 6
) (
  input  logic                        memc_clk,
  input  logic                        memc_reset,
  input  memc_types_pkg::cfg_req_t    cfg_req,
  output logic [7:0]                  cfg_rdata,
  input  memc_bist_pkg::bist_status_t status,
  output logic                        bist_start
);

  import memc_types_pkg::*;

  // only the bits that address the BRAM are reported
  localparam logic [MAX_ADDR_WIDTH-1:0] FAIL_ADDR_MASK =
    (MAX_ADDR_WIDTH'(1) << ADDR_WIDTH) - 1'b1;

  logic cfg_wr;
  logic cfg_rd;

  assign cfg_wr = cfg_req.valid && cfg_req.write;
  assign cfg_rd = cfg_req.valid && !cfg_req.write;

  always_ff @(posedge memc_clk) begin
    if (!memc_reset) begin
      bist_start <= 1'b0;
      cfg_rdata  <= '0;
    end else begin
      bist_start <= cfg_wr && (cfg_req.addr == reg_ctrl) && cfg_req.wdata[0];
      if (cfg_rd) begin
        case (cfg_req.addr)
          reg_ctrl:      cfg_rdata <= '0;  // start bit clears itself
          reg_status:    cfg_rdata <= {5'b0, status.busy, status.fail, status.done};
          reg_fail_addr: cfg_rdata <= 8'(status.fail_addr & FAIL_ADDR_MASK);
          default:       cfg_rdata <= '0;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: design/memc_top.sv
`timescale 1ns/1ps
`default_nettype none

module memc_top #(
  parameter int ADDR_WIDTH  = 6,
  parameter int DATA_WIDTH  = 8,
  parameter int QUEUE_DEPTH = 4  // also the host's starting credits
) (
  input  logic                      memc_clk,
  input  logic                      memc_reset,
  input  memc_types_pkg::memc_req_t req,
  output logic                      credit_return,
  output memc_types_pkg::memc_rsp_t rsp,
  input  memc_types_pkg::cfg_req_t  cfg_req,
  output logic [7:0]                cfg_rdata
);

  import memc_types_pkg::*;
  import memc_bist_pkg::*;

  memc_req_t             head;
  logic                  pop;
  logic                  bram_en;
  logic                  bram_we;
  logic [ADDR_WIDTH-1:0] bram_addr;
  logic [DATA_WIDTH-1:0] bram_wdata;
  logic [DATA_WIDTH-1:0] bram_rdata;
  logic                  bist_start;
  bist_status_t          status;

  memc_req_queue #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) queue0 (
    .memc_clk     (memc_clk),
    .memc_reset   (memc_reset),
    .req          (req),
    .pop          (pop),
    .head         (head),
    .credit_return(credit_return)
  );

  memc_ctrl #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) ctrl0 (
    .memc_clk  (memc_clk),
    .memc_reset(memc_reset),
    .head      (head),
    .pop       (pop),
    .rsp       (rsp),
    .bram_en   (bram_en),
    .bram_we   (bram_we),
    .bram_addr (bram_addr),
    .bram_wdata(bram_wdata),
    .bram_rdata(bram_rdata),
    .bist_start(bist_start),
    .status    (status)
  );

  memc_bram #(
    .DATA_WIDTH(DATA_WIDTH),
    .ADDR_WIDTH(ADDR_WIDTH)
  ) bram0 (
    .memc_clk(memc_clk),
    .en      (bram_en),
    .we      (bram_we),
    .addr    (bram_addr),
    .wdata   (bram_wdata),
    .rdata   (bram_rdata)
  );

  memc_cfg_regs #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) regs0 (
    .memc_clk  (memc_clk),
    .memc_reset(memc_reset),
    .cfg_req   (cfg_req),
    .cfg_rdata (cfg_rdata),
    .status    (status),
    .bist_start(bist_start)
  );

endmodule

`default_nettype wire

// File: test/memc_checker.sv
`timescale 1ns/1ps
`default_nettype none

module memc_checker #(
  parameter int ADDR_WIDTH  = 6,
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                      memc_clk,
  input  logic                      memc_reset,
  input  memc_types_pkg::memc_req_t req,
  input  logic                      credit_return,
  input  memc_types_pkg::memc_rsp_t rsp,
  input  memc_types_pkg::cfg_req_t  cfg_req,
  input  logic [7:0]                cfg_rdata,
  input  logic                      cfg_check,
  input  logic [7:0]                cfg_expect,
  input  logic                      run_end,
  output int                        data_errors,
  output int                        reg_errors,
  output int                        flow_errors
);

  import memc_types_pkg::*;

  logic [7:0]  shadow [2**ADDR_WIDTH];
  memc_req_t   req_s;
  cfg_req_t    cfg_s;
  logic        check_s;
  logic [7:0]  expect_s;
  logic        end_s;
  logic [20:0] order_q [$];  // {is read, addr, expected data}
  logic [51:0] read_q [$];   // {due cycle, addr, expected data}
  logic [51:0] head;
  int          ncyc;
  int          reqs_seen;
  int          credits_seen;

  // inputs change on the falling edge
  always @(posedge memc_clk) begin
    req_s    <= req;
    cfg_s    <= cfg_req;
    check_s  <= cfg_check;
    expect_s <= cfg_expect;
    end_s    <= run_end;
  end

  always @(negedge memc_clk) begin
    if (!memc_reset) begin
      foreach (shadow[i]) shadow[i] = 8'hAA;  // what a clean self-test leaves
      order_q.delete();
      read_q.delete();
      ncyc         = 0;
      reqs_seen    = 0;
      credits_seen = 0;
      data_errors  = 0;
      reg_errors   = 0;
      flow_errors  = 0;
    end else begin
      ncyc++;
      if (rsp.valid) begin
        if (read_q.size() == 0) begin
          $display("read response at cycle %0d with no read outstanding", ncyc);
          flow_errors++;
        end else begin
          head = read_q.pop_front();
          if (head[51:20] != 32'(ncyc)) begin
            $display("read response for addr %h came at cycle %0d, due at %0d",
                     head[19:8], ncyc, head[51:20]);
            flow_errors++;
          end
          if (rsp.rdata !== head[7:0]) begin
            $display("mismatch rsp.rdata addr %h: got %h expected %h",
                     head[19:8], rsp.rdata, head[7:0]);
            data_errors++;
          end
        end
      end else if (read_q.size() != 0 && read_q[0][51:20] == 32'(ncyc)) begin
        head = read_q.pop_front();
        $display("no read response for addr %h at cycle %0d", head[19:8], ncyc);
        flow_errors++;
      end

      // credit comes one cycle after the pop, the response two cycles later
      if (credit_return) begin
        credits_seen++;
        if (order_q.size() == 0) begin
          $display("credit returned with no request outstanding");
          flow_errors++;
        end else begin
          if (order_q[0][20]) read_q.push_back({32'(ncyc + 2), order_q[0][19:0]});
          order_q.delete(0);
        end
      end

      if (req_s.valid) begin
        reqs_seen++;
        if (req_s.op == op_write) begin
          shadow[req_s.addr[ADDR_WIDTH-1:0]] = req_s.wdata;
          order_q.push_back({1'b0, req_s.addr, req_s.wdata});
        end else begin
          order_q.push_back({1'b1, req_s.addr, shadow[req_s.addr[ADDR_WIDTH-1:0]]});
        end
      end

      if (cfg_s.valid && cfg_s.write && cfg_s.addr == reg_ctrl && cfg_s.wdata[0]) begin
        foreach (shadow[i]) shadow[i] = 8'hAA;  // rerun rewrites every word
      end
      if (cfg_s.valid && !cfg_s.write && check_s && cfg_rdata !== expect_s) begin
        $display("mismatch cfg_rdata reg %0d: got %h expected %h",
                 cfg_s.addr, cfg_rdata, expect_s);
        reg_errors++;
      end

      if (end_s) begin
        if (reqs_seen != credits_seen) begin
          $display("%0d requests sent but %0d credits returned", reqs_seen, credits_seen);
          flow_errors++;
        end
        if (order_q.size() != 0 || read_q.size() != 0) begin
          $display("requests still unanswered at the end of the run");
          flow_errors++;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: test/memc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module memc_tb;

  import memc_types_pkg::*;

  localparam int ADDR_WIDTH   = 6;
  localparam int DATA_WIDTH   = 8;
  localparam int QUEUE_DEPTH  = 4;
  localparam int RESET_CYCLES = 8;
  localparam int RAND_PAIRS   = 24;
  localparam int BIST_CYCLES  = 7 * (2 ** ADDR_WIDTH) + 2;
  localparam logic [11:0] ADDR_MASK = 12'((1 << ADDR_WIDTH) - 1);

  logic        memc_clk;
  logic        memc_reset;
  memc_req_t   req;
  logic        credit_return;
  memc_rsp_t   rsp;
  cfg_req_t    cfg_req;
  logic [7:0]  cfg_rdata;
  logic        cfg_check;
  logic [7:0]  cfg_expect;
  logic        run_end;
  bit          run_done;
  bit          timed_out;
  int          data_errors;
  int          reg_errors;
  int          flow_errors;
  int          other_errors;
  int          limit;
  int          cycles;
  int          sent;
  int          returned;
  int          reads_sent;
  int          rsp_seen;
  logic [7:0]  op_list [$];
  logic [31:0] arg_a [$];
  logic [31:0] arg_b [$];

  initial begin
    memc_clk = 1'b0;
    forever #2 memc_clk = ~memc_clk;  // 4 ns
  end

  memc_top #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) dut0 (
    .memc_clk     (memc_clk),
    .memc_reset   (memc_reset),
    .req          (req),
    .credit_return(credit_return),
    .rsp          (rsp),
    .cfg_req      (cfg_req),
    .cfg_rdata    (cfg_rdata)
  );

  memc_checker #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) chk0 (
    .memc_clk     (memc_clk),
    .memc_reset   (memc_reset),
    .req          (req),
    .credit_return(credit_return),
    .rsp          (rsp),
    .cfg_req      (cfg_req),
    .cfg_rdata    (cfg_rdata),
    .cfg_check    (cfg_check),
    .cfg_expect   (cfg_expect),
    .run_end      (run_end),
    .data_errors  (data_errors),
    .reg_errors   (reg_errors),
    .flow_errors  (flow_errors)
  );

  always @(posedge memc_clk) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles >= limit && !timed_out) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      timed_out <= 1'b1;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // every wait of the driver goes through here, so no credit or response is missed
  task automatic step();
    @(negedge memc_clk);
    if (credit_return) returned++;
    if (rsp.valid) rsp_seen++;
  endtask

  task automatic issue_req(input memc_op_e op, input logic [11:0] addr,
                           input logic [7:0] data);
    while (sent - returned >= QUEUE_DEPTH) step();  // out of credits
    req.valid = 1'b1;
    req.op    = op;
    req.addr  = addr;
    req.wdata = data;
    sent++;
    if (op == op_read) reads_sent++;
    step();
    req = '0;
  endtask

  task automatic reg_access(input logic write, input logic [1:0] addr,
                            input logic [7:0] data, input logic check);
    cfg_req.valid = 1'b1;
    cfg_req.write = write;
    cfg_req.addr  = cfg_addr_e'(addr);
    cfg_req.wdata = write ? data : 8'h00;
    cfg_check     = check;
    cfg_expect    = data;
    step();
    cfg_req   = '0;  // read data is on cfg_rdata now
    cfg_check = 1'b0;
  endtask

  task automatic drain();
    while (sent != returned || reads_sent != rsp_seen) step();
  endtask

  task automatic wait_done();
    logic [7:0] st;
    st = '0;
    while (!st[0] && !st[1]) begin
      reg_access(1'b0, 2'd1, 8'h00, 1'b0);
      st = cfg_rdata;
    end
    if (st[1]) begin
      $display("self-test stopped on a failing word");
      other_errors++;
    end
  endtask

  initial begin : driver
    int          fd;
    int          n;
    logic [7:0]  op_c;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] seed;
    logic [11:0] addr;
    string       line;
    memc_reset = 1'b0;
    req        = '0;
    cfg_req    = '0;
    cfg_check  = 1'b0;
    cfg_expect = 8'h00;
    run_end    = 1'b0;
    fd = $fopen("test/memc_input.txt", "r");
    if (fd == 0) begin
      $display("could not open test/memc_input.txt");
      other_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() > 1 && line[0] != "#") begin
          f1 = '0;
          f2 = '0;
          n = $sscanf(line, "%c %h %h", op_c, f1, f2);
          op_list.push_back(op_c);
          arg_a.push_back(f1);
          arg_b.push_back(f2);
        end
      end
      $fclose(fd);
    end
    limit = 2 * BIST_CYCLES + RESET_CYCLES + 8 * (op_list.size() + 2 * RAND_PAIRS);

    repeat (RESET_CYCLES) step();
    memc_reset = 1'b1;

    foreach (op_list[i]) begin
      case (op_list[i])
        "W": issue_req(op_write, arg_a[i][11:0], arg_b[i][7:0]);
        "R": issue_req(op_read, arg_a[i][11:0], 8'h00);
        "S": reg_access(1'b0, arg_a[i][1:0], arg_b[i][7:0], 1'b1);
        "C": begin
          drain();  // queued requests finish before a rerun
          reg_access(1'b1, arg_a[i][1:0], arg_b[i][7:0], 1'b0);
          repeat (2) step();  // start pulse, then the rerun is taken
        end
        "B": begin
          wait_done();
          drain();
        end
        default: begin
          $display("unknown operation letter %c in test/memc_input.txt", op_list[i]);
          other_errors++;
        end
      endcase
    end

    seed = 32'h7e77063d;
    repeat (RAND_PAIRS) begin
      seed = lcg_next(seed);
      addr = seed[27:16] & ADDR_MASK;
      issue_req(op_write, addr, seed[15:8]);
      issue_req(op_read, addr, 8'h00);
    end

    drain();
    run_end = 1'b1;
    step();
    run_end = 1'b0;
    @(posedge memc_clk);
    run_done = 1'b1;
  end

  initial begin : closing
    int total;
    wait (run_done || timed_out);
    total = data_errors + reg_errors + flow_errors + other_errors + int'(timed_out);
    $display("errors: data=%0d reg=%0d flow=%0d other=%0d timeout=%0d",
             data_errors, reg_errors, flow_errors, other_errors, int'(timed_out));
    if (total == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
design/memc_types_pkg.sv
design/memc_bist_pkg.sv
design/memc_req_queue.sv
design/memc_bram.sv
design/memc_ctrl.sv
design/memc_cfg_regs.sv
design/memc_top.sv
test/memc_checker.sv
test/memc_tb.sv

// File: Makefile
TOP := memc_tb
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f project.f -o $(TOP)

run: compile
	-./$(OBJ)/$(TOP) > run.log 2>&1
	@cat run.log
	@if grep -q "=== FAIL ===" run.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" run.log; then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ) run.log

// File: test/memc_input.txt
# op: W addr data | R addr | C reg data | S reg expected | B waits for self-test done
# fields in hex; reg 0 ctrl, 1 status {busy,fail,done}, 2 fail_addr
S 1 04
S 2 00
S 3 00
W 05 3c
W 3f c3
R 05
R 00
S 1 04
R 3f
W 10 7e
R 10
B
S 1 01
S 2 00
S 0 00
R 3f
R 05
R 01
R 10
W 20 11
W 21 22
R 21
R 20
C 0 01
S 1 04
B
S 1 01
S 2 00
R 05
R 3f
R 20
R 00
